// ==== logic/csr_config_pkg.sv ====
package csr_config_pkg;

    // --------------------------------------
    // Response word widths
    // --------------------------------------
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 32;
    localparam int SHIFT_W = 5;

    // Route id widths
    localparam int CMD_W    = 3;
    localparam int MODULE_W = 2;
    localparam int ENGINE_W = 3;
    localparam int BUFFER_W = 3;

    // Number of record positions that carry fields
    localparam int DECODED_WORDS = 8;

    typedef enum logic [CMD_W-1:0] {
        CMD_MEM_INVALID   = 3'd0,
        CMD_MEM_READ      = 3'd1,
        CMD_MEM_WRITE     = 3'd2,
        CMD_MEM_CONFIGURE = 3'd3
    } memory_cmd_e;

    // --------------------------------------
    // Config data word views
    // --------------------------------------
    // id_buffer shares bit 9 with id_engine, so it has its own view
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [DATA_W-6:0] reserved;
            logic              mode_break;
            logic              mode_buffer;
            logic              mode_sequence;
            logic              decrement;
            logic              increment;
        } flags;
        struct packed {
            logic                      direction;
            logic [DATA_W-SHIFT_W-2:0] reserved;
            logic [SHIFT_W-1:0]        granularity;
        } shift;
        struct packed {
            logic [DATA_W-11:0]  reserved;
            logic [ENGINE_W-1:0] id_engine;
            logic [1:0]          gap;
            logic [MODULE_W-1:0] id_module;
            memory_cmd_e         cmd;
        } route;
        struct packed {
            logic [DATA_W-13:0]  reserved;
            logic [BUFFER_W-1:0] id_buffer;
            logic [8:0]          low;
        } buffer;
    } config_word_u;

    // --------------------------------------
    // Packed record layout from bit 0 up
    // --------------------------------------
    localparam int FLAGS_W = 5;

    localparam int CFG_INCREMENT_LSB     = 0;
    localparam int CFG_DECREMENT_LSB     = 1;
    localparam int CFG_MODE_SEQUENCE_LSB = 2;
    localparam int CFG_MODE_BUFFER_LSB   = 3;
    localparam int CFG_MODE_BREAK_LSB    = 4;
    localparam int CFG_INDEX_START_LSB   = CFG_INCREMENT_LSB + FLAGS_W;
    localparam int CFG_INDEX_END_LSB     = CFG_INDEX_START_LSB + DATA_W;
    localparam int CFG_STRIDE_LSB        = CFG_INDEX_END_LSB + DATA_W;
    localparam int CFG_GRANULARITY_LSB   = CFG_STRIDE_LSB + DATA_W;
    localparam int CFG_DIRECTION_LSB     = CFG_GRANULARITY_LSB + SHIFT_W;
    localparam int CFG_CMD_LSB           = CFG_DIRECTION_LSB + 1;
    localparam int CFG_ID_MODULE_LSB     = CFG_CMD_LSB + CMD_W;
    localparam int CFG_ID_ENGINE_LSB     = CFG_ID_MODULE_LSB + MODULE_W;
    localparam int CFG_ID_BUFFER_LSB     = CFG_ID_ENGINE_LSB + ENGINE_W;
    localparam int CFG_ARRAY_SIZE_LSB    = CFG_ID_BUFFER_LSB + BUFFER_W;

    localparam int CONFIG_W = FLAGS_W + 4 * DATA_W + SHIFT_W + 1
                            + CMD_W + MODULE_W + ENGINE_W + BUFFER_W;

endpackage

// ==== logic/response_window_filter.sv ====
`timescale 1ns/100ps

module response_window_filter
    import csr_config_pkg::*;
#(
    parameter int ENGINE_SEQ_WIDTH = 16,
    parameter int ID_RELATIVE      = 0
) (
    input  logic               ap_clk,
    input  logic               areset_csr_index_generator,
    input  logic               response_valid,
    input  logic [ADDR_W-1:0]  response_offset,
    input  logic [SHIFT_W-1:0] response_shift,
    input  logic [DATA_W-1:0]  response_data,
    output logic               word_valid,
    output logic               word_first,
    output logic [DATA_W-1:0]  word_data
);

    // Window bounds with SEQ_MAX excluded
    localparam logic [ADDR_W-1:0] SEQ_MIN = ADDR_W'(ID_RELATIVE * ENGINE_SEQ_WIDTH);
    localparam logic [ADDR_W-1:0] SEQ_MAX = ADDR_W'((ID_RELATIVE + 1) * ENGINE_SEQ_WIDTH);

    logic               valid_q;
    logic [ADDR_W-1:0]  offset_q;
    logic [SHIFT_W-1:0] shift_q;
    logic [DATA_W-1:0]  data_q;
    logic [ADDR_W-1:0]  seq_num;
    logic               in_window;

    // --------------------------------------
    // Input register
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= response_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        offset_q <= response_offset;
        shift_q  <= response_shift;
        data_q   <= response_data;
    end

    // --------------------------------------
    // Sequence number and window test
    // --------------------------------------
    assign seq_num   = offset_q >> shift_q;
    assign in_window = (seq_num >= SEQ_MIN) && (seq_num < SEQ_MAX);

    assign word_valid = valid_q & in_window;
    assign word_first = (seq_num == SEQ_MIN);
    assign word_data  = data_q;

endmodule

// ==== logic/config_word_decoder.sv ====
`timescale 1ns/100ps

module config_word_decoder
    import csr_config_pkg::*;
#(
    parameter int ENGINE_SEQ_WIDTH = 16
) (
    input  logic                ap_clk,
    input  logic                areset_csr_index_generator,
    input  logic                word_valid,
    input  logic                word_first,
    input  logic [DATA_W-1:0]   word_data,
    output logic                record_valid,
    output logic [CONFIG_W-1:0] record
);

    localparam logic [ENGINE_SEQ_WIDTH-1:0] POS_ONE = ENGINE_SEQ_WIDTH'(1);

    // One-hot record position that stays zero while no record is open
    logic [ENGINE_SEQ_WIDTH-1:0] position;
    logic                        emit;
    logic                        word_valid_d;
    config_word_u                word_d;
    logic                        decode_hit;
    logic [CONFIG_W-1:0]         record_q;

    // --------------------------------------
    // Position tracking and emit strobe
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            position     <= '0;
            emit         <= 1'b0;
            record_valid <= 1'b0;
            word_valid_d <= 1'b0;
        end else begin
            // Single pulse once the last position is reached
            emit         <= position[ENGINE_SEQ_WIDTH-1] & ~emit;
            record_valid <= emit;
            word_valid_d <= word_valid;

            if (word_valid) begin
                if (word_first && !(|position)) begin
                    position <= POS_ONE;
                end else begin
                    // Stray words with no open record shift zero and vanish
                    position <= position << 1;
                end
            end else if (emit) begin
                position <= '0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        word_d <= word_data;
    end

    // Only the low positions carry fields
    assign decode_hit = |position[DECODED_WORDS-1:0];

    // --------------------------------------
    // Field decode
    // --------------------------------------
    // Delayed word lines up with the position it was counted into
    always_ff @(posedge ap_clk) begin
        if (word_valid_d && decode_hit) begin
            case (position)
                POS_ONE << 0: begin
                    record_q[CFG_INCREMENT_LSB]     <= word_d.flags.increment;
                    record_q[CFG_DECREMENT_LSB]     <= word_d.flags.decrement;
                    record_q[CFG_MODE_SEQUENCE_LSB] <= word_d.flags.mode_sequence;
                    record_q[CFG_MODE_BUFFER_LSB]   <= word_d.flags.mode_buffer;
                    record_q[CFG_MODE_BREAK_LSB]    <= word_d.flags.mode_break;
                end
                POS_ONE << 1: begin
                    record_q[CFG_INDEX_START_LSB +: DATA_W] <= word_d.raw;
                end
                POS_ONE << 2: begin
                    record_q[CFG_INDEX_END_LSB +: DATA_W] <= word_d.raw;
                end
                POS_ONE << 3: begin
                    record_q[CFG_STRIDE_LSB +: DATA_W] <= word_d.raw;
                end
                POS_ONE << 4: begin
                    record_q[CFG_GRANULARITY_LSB +: SHIFT_W] <= word_d.shift.granularity;
                    record_q[CFG_DIRECTION_LSB]              <= word_d.shift.direction;
                end
                POS_ONE << 5: begin
                    // Command value passes through as is even if not enumerated
                    record_q[CFG_CMD_LSB +: CMD_W]          <= word_d.route.cmd;
                    record_q[CFG_ID_MODULE_LSB +: MODULE_W] <= word_d.route.id_module;
                    record_q[CFG_ID_ENGINE_LSB +: ENGINE_W] <= word_d.route.id_engine;
                end
                POS_ONE << 6: begin
                    record_q[CFG_ID_BUFFER_LSB +: BUFFER_W] <= word_d.buffer.id_buffer;
                end
                POS_ONE << 7: begin
                    record_q[CFG_ARRAY_SIZE_LSB +: DATA_W] <= word_d.raw;
                end
                default: begin
                end
            endcase
        end
    end

    assign record = record_q;

endmodule

// ==== logic/config_fifo.sv ====
`timescale 1ns/100ps

module config_fifo #(
    parameter int FIFO_DEPTH = 16,
    parameter int WIDTH      = 32
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic             dout_valid,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             rd_req_q;
    logic             push;
    logic             pop;
    logic             rd_valid_q;
    logic [WIDTH-1:0] rd_data_q;

    // Writes while full are dropped
    assign push  = wr_en & ~full;
    assign pop   = rd_req_q & ~empty;
    assign empty = (count == '0);
    assign full  = (count == (AW + 1)'(FIFO_DEPTH));

    // --------------------------------------
    // Pointers, occupancy, read request
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_req_q   <= 1'b0;
            rd_valid_q <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            rd_req_q   <= rd_en;
            rd_valid_q <= pop;
            dout_valid <= rd_valid_q;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW + 1)'(push) - (AW + 1)'(pop);
        end
    end

    // --------------------------------------
    // Storage and output registers
    // --------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        if (pop) begin
            rd_data_q <= mem[rd_ptr];
        end
        dout <= rd_data_q;
    end

endmodule

// ==== logic/csr_index_configure_memory.sv ====
`timescale 1ns/100ps

module csr_index_configure_memory
    import csr_config_pkg::*;
#(
    parameter int ENGINE_SEQ_WIDTH = 16,
    parameter int ID_RELATIVE      = 0,
    parameter int FIFO_DEPTH       = 16
) (
    input  logic                ap_clk,
    input  logic                areset_csr_index_generator,
    input  logic                response_valid,
    input  logic [ADDR_W-1:0]   response_offset,
    input  logic [SHIFT_W-1:0]  response_shift,
    input  logic [DATA_W-1:0]   response_data,
    input  logic                config_rd_en,
    output logic                config_valid,
    output logic                config_empty,
    output logic                config_full,
    output logic                increment,
    output logic                decrement,
    output logic                mode_sequence,
    output logic                mode_buffer,
    output logic                mode_break,
    output logic [DATA_W-1:0]   index_start,
    output logic [DATA_W-1:0]   index_end,
    output logic [DATA_W-1:0]   stride,
    output logic [SHIFT_W-1:0]  granularity,
    output logic                direction,
    output memory_cmd_e         cmd,
    output logic [MODULE_W-1:0] id_module,
    output logic [ENGINE_W-1:0] id_engine,
    output logic [BUFFER_W-1:0] id_buffer,
    output logic [DATA_W-1:0]   array_size
);

    logic                word_valid;
    logic                word_first;
    logic [DATA_W-1:0]   word_data;
    logic                record_valid;
    logic [CONFIG_W-1:0] record;
    logic [CONFIG_W-1:0] config_record;

    // --------------------------------------
    // Pipeline stages
    // --------------------------------------
    response_window_filter #(
        .ENGINE_SEQ_WIDTH(ENGINE_SEQ_WIDTH),
        .ID_RELATIVE     (ID_RELATIVE)
    ) response_window_filter_inst (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_valid            (response_valid),
        .response_offset           (response_offset),
        .response_shift            (response_shift),
        .response_data             (response_data),
        .word_valid                (word_valid),
        .word_first                (word_first),
        .word_data                 (word_data)
    );

    config_word_decoder #(
        .ENGINE_SEQ_WIDTH(ENGINE_SEQ_WIDTH)
    ) config_word_decoder_inst (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .word_valid                (word_valid),
        .word_first                (word_first),
        .word_data                 (word_data),
        .record_valid              (record_valid),
        .record                    (record)
    );

    config_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .WIDTH     (CONFIG_W)
    ) config_fifo_inst (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (record_valid),
        .din                       (record),
        .rd_en                     (config_rd_en),
        .dout_valid                (config_valid),
        .dout                      (config_record),
        .empty                     (config_empty),
        .full                      (config_full)
    );

    // --------------------------------------
    // Record slicing
    // --------------------------------------
    assign increment     = config_record[CFG_INCREMENT_LSB];
    assign decrement     = config_record[CFG_DECREMENT_LSB];
    assign mode_sequence = config_record[CFG_MODE_SEQUENCE_LSB];
    assign mode_buffer   = config_record[CFG_MODE_BUFFER_LSB];
    assign mode_break    = config_record[CFG_MODE_BREAK_LSB];
    assign index_start   = config_record[CFG_INDEX_START_LSB +: DATA_W];
    assign index_end     = config_record[CFG_INDEX_END_LSB +: DATA_W];
    assign stride        = config_record[CFG_STRIDE_LSB +: DATA_W];
    assign granularity   = config_record[CFG_GRANULARITY_LSB +: SHIFT_W];
    assign direction     = config_record[CFG_DIRECTION_LSB];
    assign cmd           = memory_cmd_e'(config_record[CFG_CMD_LSB +: CMD_W]);
    assign id_module     = config_record[CFG_ID_MODULE_LSB +: MODULE_W];
    assign id_engine     = config_record[CFG_ID_ENGINE_LSB +: ENGINE_W];
    assign id_buffer     = config_record[CFG_ID_BUFFER_LSB +: BUFFER_W];
    assign array_size    = config_record[CFG_ARRAY_SIZE_LSB +: DATA_W];

endmodule

// ==== tests/tb_csr_index_configure_memory.sv ====
`timescale 1ns/100ps

module tb_csr_index_configure_memory;

    localparam int          SEQ_W       = 16;
    localparam int          ID_REL      = 1;
    localparam logic [31:0] WINDOW_BASE = 32'(ID_REL * SEQ_W);
    localparam int          MAX_CYCLES  = 4000;

    typedef struct packed {
        logic        increment;
        logic        decrement;
        logic        mode_sequence;
        logic        mode_buffer;
        logic        mode_break;
        logic [31:0] index_start;
        logic [31:0] index_end;
        logic [31:0] stride;
        logic [4:0]  granularity;
        logic        direction;
        logic [2:0]  cmd;
        logic [1:0]  id_module;
        logic [2:0]  id_engine;
        logic [2:0]  id_buffer;
        logic [31:0] array_size;
    } expected_t;

    logic        ap_clk;
    logic        areset_csr_index_generator;
    logic        response_valid;
    logic [31:0] response_offset;
    logic [4:0]  response_shift;
    logic [31:0] response_data;
    logic        config_rd_en;
    logic        config_valid;
    logic        config_empty;
    logic        config_full;
    logic        increment;
    logic        decrement;
    logic        mode_sequence;
    logic        mode_buffer;
    logic        mode_break;
    logic [31:0] index_start;
    logic [31:0] index_end;
    logic [31:0] stride;
    logic [4:0]  granularity;
    logic        direction;
    logic [2:0]  cmd;
    logic [1:0]  id_module;
    logic [2:0]  id_engine;
    logic [2:0]  id_buffer;
    logic [31:0] array_size;

    expected_t          exp_q[$];
    logic [15:0][31:0]  rec_words;
    int                 error_count    = 0;
    int                 received_count = 0;
    int                 pass_tests     = 0;
    int                 fail_tests     = 0;
    int                 cycle_count    = 0;

    csr_index_configure_memory #(
        .ENGINE_SEQ_WIDTH(SEQ_W),
        .ID_RELATIVE     (ID_REL),
        .FIFO_DEPTH      (16)
    ) csr_index_configure_memory_inst (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_valid            (response_valid),
        .response_offset           (response_offset),
        .response_shift            (response_shift),
        .response_data             (response_data),
        .config_rd_en              (config_rd_en),
        .config_valid              (config_valid),
        .config_empty              (config_empty),
        .config_full               (config_full),
        .increment                 (increment),
        .decrement                 (decrement),
        .mode_sequence             (mode_sequence),
        .mode_buffer               (mode_buffer),
        .mode_break                (mode_break),
        .index_start               (index_start),
        .index_end                 (index_end),
        .stride                    (stride),
        .granularity               (granularity),
        .direction                 (direction),
        .cmd                       (cmd),
        .id_module                 (id_module),
        .id_engine                 (id_engine),
        .id_buffer                 (id_buffer),
        .array_size                (array_size)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic expected_t expected_config(input logic [15:0][31:0] words);
        expected_t e;
        e.increment     = words[0][0];
        e.decrement     = words[0][1];
        e.mode_sequence = words[0][2];
        e.mode_buffer   = words[0][3];
        e.mode_break    = words[0][4];
        e.index_start   = words[1];
        e.index_end     = words[2];
        e.stride        = words[3];
        e.granularity   = words[4][4:0];
        e.direction     = words[4][31];
        e.cmd           = words[5][2:0];
        e.id_module     = words[5][4:3];
        e.id_engine     = words[5][9:7];
        e.id_buffer     = words[6][11:9];
        // Positions 8 to 15 carry nothing
        e.array_size    = words[7];
        return e;
    endfunction

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic drive_response(input logic [31:0] offset, input logic [4:0] shift,
                                  input logic [31:0] data);
        @(posedge ap_clk);
        response_valid  <= 1'b1;
        response_offset <= offset;
        response_shift  <= shift;
        response_data   <= data;
    endtask

    task automatic hold_idle(input int cycles);
        repeat (cycles) begin
            @(posedge ap_clk);
            response_valid <= 1'b0;
        end
    endtask

    task automatic fill_random_words(output logic [15:0][31:0] words);
        for (int k = 0; k < 16; k++) begin
            words[k] = $urandom;
        end
    endtask

    // Word k carries window sequence number k scaled up by the shift
    task automatic send_record(input logic [15:0][31:0] words, input logic [4:0] shift,
                               input bit interleave);
        logic [31:0] seq;
        exp_q.push_back(expected_config(words));
        for (int k = 0; k < 16; k++) begin
            seq = WINDOW_BASE + 32'(k);
            drive_response(seq << shift, shift, words[k]);
            if (interleave) begin
                // Neighbour windows 0 and 2 take turns
                if (k % 2 == 0) begin
                    drive_response(32'(k) << shift, shift, $urandom);
                end else begin
                    drive_response((WINDOW_BASE + 32'(SEQ_W + k)) << shift, shift, $urandom);
                end
            end
        end
        // Decoder needs a few quiet cycles before the next record opens
        hold_idle(6);
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(negedge ap_clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("records missing: %0d record(s) never left the DUT", exp_q.size());
            error_count++;
            exp_q.delete();
        end
        // Room for a stray extra config_valid to show up
        repeat (8) @(negedge ap_clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_tests++;
            $display("Test %s: ok", name);
        end else begin
            fail_tests++;
            $display("Test %s: failed with %0d error(s)", name, error_count - errors_before);
        end
    endtask

    // ----------------------------------------
    // Output checking
    // ----------------------------------------
    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("[ERROR] %0t: field %s is %h, expected %h", $time, name, got, want);
            error_count++;
        end
    endtask

    initial begin : compare_records
        expected_t want;
        forever begin
            @(negedge ap_clk);
            if (config_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("unexpected record: config_valid at %0t with none expected",
                             $time);
                    error_count++;
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    check_field("increment", 32'(increment), 32'(want.increment));
                    check_field("decrement", 32'(decrement), 32'(want.decrement));
                    check_field("mode_sequence", 32'(mode_sequence), 32'(want.mode_sequence));
                    check_field("mode_buffer", 32'(mode_buffer), 32'(want.mode_buffer));
                    check_field("mode_break", 32'(mode_break), 32'(want.mode_break));
                    check_field("index_start", index_start, want.index_start);
                    check_field("index_end", index_end, want.index_end);
                    check_field("stride", stride, want.stride);
                    check_field("granularity", 32'(granularity), 32'(want.granularity));
                    check_field("direction", 32'(direction), 32'(want.direction));
                    check_field("cmd", 32'(cmd), 32'(want.cmd));
                    check_field("id_module", 32'(id_module), 32'(want.id_module));
                    check_field("id_engine", 32'(id_engine), 32'(want.id_engine));
                    check_field("id_buffer", 32'(id_buffer), 32'(want.id_buffer));
                    check_field("array_size", array_size, want.array_size);
                    received_count++;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < MAX_CYCLES) begin
            @(posedge ap_clk);
            cycle_count++;
        end
        $display("Timeout: run went past %0d cycles", MAX_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : run_tests
        int errors_before;
        int seen_before;
        areset_csr_index_generator = 1'b1;
        response_valid             = 1'b0;
        response_offset            = '0;
        response_shift             = '0;
        response_data              = '0;
        config_rd_en               = 1'b0;
        void'($urandom(32'he3c7));

        repeat (10) @(posedge ap_clk);
        areset_csr_index_generator <= 1'b0;
        config_rd_en               <= 1'b1;

        errors_before = error_count;
        repeat (20) begin
            @(negedge ap_clk);
            assert (!config_valid && config_empty && !config_full) else begin
                $display("[ERROR] %0t: after reset valid=%b empty=%b full=%b", $time,
                         config_valid, config_empty, config_full);
                error_count++;
            end
        end
        report_test("idle after reset", errors_before);

        errors_before = error_count;
        fill_random_words(rec_words);
        send_record(rec_words, 5'd2, 1'b0);
        wait_drain(200);
        report_test("single record", errors_before);

        errors_before = error_count;
        fill_random_words(rec_words);
        send_record(rec_words, 5'd2, 1'b1);
        wait_drain(200);
        report_test("window filter", errors_before);

        errors_before = error_count;
        drive_response((WINDOW_BASE + 32'd3) << 2, 5'd2, $urandom);
        hold_idle(6);
        fill_random_words(rec_words);
        send_record(rec_words, 5'd2, 1'b0);
        wait_drain(200);
        report_test("stray word", errors_before);

        errors_before = error_count;
        @(posedge ap_clk);
        config_rd_en <= 1'b0;
        hold_idle(2);
        seen_before = received_count;
        for (int r = 0; r < 5; r++) begin
            fill_random_words(rec_words);
            send_record(rec_words, 5'd2, 1'b0);
        end
        hold_idle(10);
        @(negedge ap_clk);
        assert (received_count == seen_before && !config_empty && exp_q.size() == 5) else begin
            $display("[ERROR] %0t: back-pressure got %0d record(s), empty=%b, queued=%0d",
                     $time, received_count - seen_before, config_empty, exp_q.size());
            error_count++;
        end
        @(posedge ap_clk);
        config_rd_en <= 1'b1;
        wait_drain(300);
        report_test("back-pressure", errors_before);

        errors_before = error_count;
        fill_random_words(rec_words);
        send_record(rec_words, 5'd0, 1'b0);
        send_record(rec_words, 5'd2, 1'b0);
        wait_drain(200);
        report_test("shift amount", errors_before);

        $display("Summary: %0d test(s) ok, %0d test(s) failed, %0d error(s)",
                 pass_tests, fail_tests, error_count);
        if (error_count == 0 && fail_tests == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/csr_config_pkg.sv
logic/response_window_filter.sv
logic/config_word_decoder.sv
logic/config_fifo.sv
logic/csr_index_configure_memory.sv
tests/tb_csr_index_configure_memory.sv

// ==== Makefile ====
# Verilator build and run for the CSR config loader

TOP := tb_csr_index_configure_memory

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard logic/*.sv tests/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

# Pass only when the testbench printed its pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
